//--- bench/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
    import core_types::*;
    import mem_types::*;
();

    logic           clk;
    logic           rst_i;
    logic           ex_valid_i;
    logic           ex_ready_o;
    ex_mem_struct   ex_i;
    logic           llbit_clr_i;
    logic           wb_valid_o;
    logic           wb_ready_i;
    mem_resp_struct wb_o;

    logic [3:0]     op_q [$];
    data_t          addr_q [$];
    data_t          data_q [$];
    logic           clr_q [$];
    data_t          result_q [$];
    logic           ale_q [$];

    logic [15:0]    lfsr;
    int             cycles = 0;
    int             limit;
    mem_resp_struct held;

    mem_stage #(
        .addr_bits_p (8)
    ) i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex_valid_i  (ex_valid_i),
        .ex_ready_o  (ex_ready_o),
        .ex_i        (ex_i),
        .llbit_clr_i (llbit_clr_i),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_o        (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic flag_mismatch(input string name, input data_t got, input data_t exp);
        $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("At %0d ns: %s", $time, what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        lfsr       = lfsr_step(lfsr);
        wb_ready_i = lfsr[0];                   // One bit per step.
    endtask

    // Puts one test line on the execute bus.
    task automatic offer_op(input int idx);
        ex_valid_i = 1'b1;
        ex_i.op    = mem_op_e'(op_q[idx]);
        ex_i.addr  = addr_q[idx];
        ex_i.data  = data_q[idx];
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            abort_run($sformatf("the run did not finish within %0d cycles", limit));
        end
    end

    // ==================================================================
    // Stimulus and checks
    // ==================================================================

    initial begin
        int         fd;
        int         n;
        string      line;
        logic [3:0] op_v;
        data_t      addr_v;
        data_t      data_v;
        logic [3:0] clr_v;
        data_t      res_v;
        logic [3:0] ale_v;

        rst_i       = 1'b1;
        ex_valid_i  = 1'b0;
        ex_i        = '0;
        llbit_clr_i = 1'b0;
        wb_ready_i  = 1'b0;
        lfsr        = 16'd29;
        limit       = 0;

        fd = $fopen("bench/mem_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/mem_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h",
                            op_v, addr_v, data_v, clr_v, res_v, ale_v);
                if (n != 6) begin
                    abort_run("malformed line in the test file");
                end
                op_q.push_back(op_v);
                addr_q.push_back(addr_v);
                data_q.push_back(data_v);
                clr_q.push_back(clr_v[0]);
                result_q.push_back(res_v);
                ale_q.push_back(ale_v[0]);
            end
        end
        $fclose(fd);
        limit = 20 * op_q.size() + 50;

        repeat (3) @(negedge clk);
        rst_i = 1'b0;

        foreach (op_q[i]) begin
            if (!ex_valid_i) begin
                next_cycle();
                assert (!wb_valid_o) else abort_run("a response was delivered twice");
                if (clr_q[i]) begin
                    llbit_clr_i = 1'b1;
                    next_cycle();
                    llbit_clr_i = 1'b0;
                end
                offer_op(i);
            end
            #1;
            while (!ex_ready_o) begin
                next_cycle();
                #1;
            end
            next_cycle();                       // Past the accept edge.
            if (i + 1 < op_q.size() && !clr_q[i + 1]) begin
                offer_op(i + 1);                // Waits behind the pending response.
            end else begin
                ex_valid_i = 1'b0;
            end
            assert (wb_valid_o) else abort_run("no response one cycle after accept");
            held = wb_o;
            while (!wb_ready_i) begin
                next_cycle();
                assert (wb_valid_o && wb_o === held)
                    else abort_run("response changed or dropped during a stall");
            end
            assert (wb_o.result === result_q[i])
                else flag_mismatch("wb_o.result", wb_o.result, result_q[i]);
            assert (wb_o.ale === ale_q[i])
                else flag_mismatch("wb_o.ale", data_t'(wb_o.ale), data_t'(ale_q[i]));
        end

        next_cycle();
        assert (!wb_valid_o) else abort_run("a response was delivered twice");
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- bench/mem_tests.txt
# op addr data clr result ale  (hex; op 1 LD_B 2 LD_H 3 LD_W 4 LD_BU 5 LD_HU)
# (6 ST_B 7 ST_H 8 ST_W 9 LL a SC; clr pulses llbit_clr before the op)
8 00000010 12345678 0 00000000 0
3 00000010 00000000 0 12345678 0
7 00000022 0000cdef 0 00000000 0
6 00000021 000000ab 0 00000000 0
6 00000020 00000011 0 00000000 0
3 00000020 00000000 0 cdefab11 0
6 00000033 00000056 0 00000000 0
6 00000032 00000078 0 00000000 0
7 00000030 00001234 0 00000000 0
3 00000030 00000000 0 56781234 0
8 00000040 80ff7f01 0 00000000 0
1 00000040 00000000 0 00000001 0
1 00000041 00000000 0 0000007f 0
1 00000042 00000000 0 ffffffff 0
1 00000043 00000000 0 ffffff80 0
4 00000042 00000000 0 000000ff 0
4 00000043 00000000 0 00000080 0
2 00000040 00000000 0 00007f01 0
2 00000042 00000000 0 ffff80ff 0
5 00000040 00000000 0 00007f01 0
5 00000042 00000000 0 000080ff 0
2 00000041 00000000 0 00000000 1
5 00000043 00000000 0 00000000 1
7 00000011 0000beef 0 00000000 1
8 00000012 deadbeef 0 00000000 1
3 00000013 00000000 0 00000000 1
3 00000010 00000000 0 12345678 0
8 00000050 00000000 0 00000000 0
9 00000050 00000000 0 00000000 0
a 00000050 cafef00d 0 00000001 0
a 00000050 0badf00d 0 00000000 0
9 00000050 00000000 0 cafef00d 0
a 00000050 11111111 1 00000000 0
3 00000050 00000000 0 cafef00d 0

//--- design/core_types.sv
package core_types;

    // ==================================================================
    // Machine word
    // ==================================================================

    localparam int data_w_c = 32;

    typedef logic [data_w_c-1:0] data_t;

    // ==================================================================
    // Memory opcodes from execute
    // ==================================================================

    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_H  = 4'd2,
        OP_LD_W  = 4'd3,
        OP_LD_BU = 4'd4,
        OP_LD_HU = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8,
        OP_LL    = 4'd9,
        OP_SC    = 4'd10
    } mem_op_e;

    // Execute to memory bundle.
    typedef struct packed {
        mem_op_e op;
        data_t   addr;
        data_t   data;                  // Store data, low bits for B/H.
    } ex_mem_struct;

endpackage

//--- design/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import core_types::*;
    import mem_types::*;
#(
    parameter int addr_bits_p = 8
) (
    input  logic            clk,
    input  logic            strobe_i,
    input  mem_cache_struct req_i,
    output data_t           rdata_o
);

    localparam int depth_c = 2 ** addr_bits_p;

    data_t                  mem_q [depth_c];
    logic [addr_bits_p-1:0] word_addr;
    data_t                  rdata_q;

    // Byte address to word index.
    assign word_addr = req_i.addr[addr_bits_p+1:2];

    // ==================================================================
    // Write lanes or register the read word
    // ==================================================================

    always_ff @(posedge clk) begin
        if (strobe_i && req_i.ce) begin
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_i.sel[b]) begin
                        mem_q[word_addr][b*8 +: 8] <= req_i.data[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[word_addr];    // Held until the next read.
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- design/llbit_reg.sv
`timescale 1ns/1ps

module llbit_reg
    import core_types::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    accept_i,
    input  mem_op_e op_i,
    input  logic    clr_i,
    output logic    llbit_o
);

    logic llbit_q;

    // ==================================================================
    // Reservation bit
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            llbit_q <= 1'b0;
        end else if (clr_i) begin
            llbit_q <= 1'b0;                // Clear beats a same-cycle LL.
        end else if (accept_i && op_i == OP_SC) begin
            llbit_q <= 1'b0;
        end else if (accept_i && op_i == OP_LL) begin
            llbit_q <= 1'b1;
        end
    end

    assign llbit_o = llbit_q;

endmodule

//--- design/load_align.sv
`timescale 1ns/1ps

module load_align
    import core_types::*;
    import mem_types::*;
(
    input  mem_op_e        op_i,
    input  logic [1:0]     offset_i,
    input  logic           sc_ok_i,
    input  logic           ale_i,
    input  data_t          rdata_i,
    output mem_resp_struct resp_o
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // Addressed lane shifted down.
    assign lane_byte = rdata_i[{offset_i, 3'b000} +: 8];
    assign lane_half = rdata_i[{offset_i[1], 4'b0000} +: 16];

    // ==================================================================
    // Result select and extension
    // ==================================================================

    always_comb begin
        resp_o        = '0;
        resp_o.ale    = ale_i;
        if (!ale_i) begin
            case (op_i)
                OP_LD_B: begin
                    resp_o.result = {{24{lane_byte[7]}}, lane_byte};
                end
                OP_LD_BU: begin
                    resp_o.result = {24'd0, lane_byte};
                end
                OP_LD_H: begin
                    resp_o.result = {{16{lane_half[15]}}, lane_half};
                end
                OP_LD_HU: begin
                    resp_o.result = {16'd0, lane_half};
                end
                OP_LD_W, OP_LL: begin
                    resp_o.result = rdata_i;
                end
                OP_SC: begin
                    resp_o.result = {31'd0, sc_ok_i};   // 1 on success.
                end
                default: begin
                    resp_o.result = '0;                 // Plain stores.
                end
            endcase
        end
    end

endmodule

//--- design/mem_req.sv
`timescale 1ns/1ps

module mem_req
    import core_types::*;
    import mem_types::*;
(
    input  mem_op_e         op_i,
    input  data_t           addr_i,
    input  data_t           data_i,
    input  logic            llbit_i,
    output mem_cache_struct req_o
);

    always_comb begin
        req_o = '0;

        // Decode enable, direction and width.
        case (op_i)
            OP_LD_B, OP_LD_BU: begin
                req_o.ce    = 1'b1;
                req_o.width = W_BYTE;
            end
            OP_LD_H, OP_LD_HU: begin
                req_o.ce    = 1'b1;
                req_o.width = W_HALF;
            end
            OP_LD_W, OP_LL: begin
                req_o.ce    = 1'b1;
                req_o.width = W_WORD;
            end
            OP_ST_B: begin
                req_o.ce    = 1'b1;
                req_o.we    = 1'b1;
                req_o.width = W_BYTE;
            end
            OP_ST_H: begin
                req_o.ce    = 1'b1;
                req_o.we    = 1'b1;
                req_o.width = W_HALF;
            end
            OP_ST_W: begin
                req_o.ce    = 1'b1;
                req_o.we    = 1'b1;
                req_o.width = W_WORD;
            end
            OP_SC: begin
                req_o.ce    = llbit_i;      // Fails silently without the bit.
                req_o.we    = llbit_i;
                req_o.width = W_WORD;
            end
            default: begin
                req_o.ce    = 1'b0;
            end
        endcase

        // Lanes, store data and alignment from the width.
        case (req_o.width)
            W_BYTE: begin
                req_o.sel  = 4'b0001 << addr_i[1:0];
                req_o.data = {4{data_i[7:0]}};
            end
            W_HALF: begin
                req_o.sel  = addr_i[1] ? 4'b1100 : 4'b0011;
                req_o.data = {2{data_i[15:0]}};
                req_o.ale  = addr_i[0];
            end
            default: begin
                req_o.sel  = 4'b1111;
                req_o.data = data_i;
                req_o.ale  = |addr_i[1:0];
            end
        endcase

        // A faulting or idle access never reaches the RAM.
        if (req_o.ale || !req_o.ce) begin
            req_o.ce   = 1'b0;
            req_o.we   = 1'b0;
            req_o.sel  = 4'b0000;
            req_o.data = '0;
        end else begin
            req_o.addr = addr_i;
        end
    end

endmodule

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import core_types::*;
    import mem_types::*;
#(
    parameter int addr_bits_p = 8
) (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           ex_valid_i,
    output logic           ex_ready_o,
    input  ex_mem_struct   ex_i,
    input  logic           llbit_clr_i,
    output logic           wb_valid_o,
    input  logic           wb_ready_i,
    output mem_resp_struct wb_o
);

    logic            accept;
    logic            llbit;
    mem_cache_struct req;
    data_t           rdata;

    logic            resp_valid_q;
    mem_op_e         resp_op_q;
    logic [1:0]      resp_offset_q;
    logic            resp_ale_q;
    logic            resp_sc_ok_q;

    // ==================================================================
    // Handshake
    // ==================================================================

    assign ex_ready_o = !resp_valid_q || wb_ready_i;
    assign accept     = ex_valid_i && ex_ready_o;
    assign wb_valid_o = resp_valid_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_valid_q <= 1'b0;
        end else if (accept) begin
            resp_valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end

    // One-deep response payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_op_q     <= ex_i.op;
            resp_offset_q <= ex_i.addr[1:0];
            resp_ale_q    <= req.ale;
            resp_sc_ok_q  <= (ex_i.op == OP_SC) && req.ce;
        end
    end

    // ==================================================================
    // Blocks
    // ==================================================================

    mem_req i_mem_req (
        .op_i    (ex_i.op),
        .addr_i  (ex_i.addr),
        .data_i  (ex_i.data),
        .llbit_i (llbit),
        .req_o   (req)
    );

    llbit_reg i_llbit_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .accept_i (accept && !(req.ale && ex_i.op == OP_LL)),   // Faulting LL sets no bit.
        .op_i     (ex_i.op),
        .clr_i    (llbit_clr_i),
        .llbit_o  (llbit)
    );

    data_ram #(
        .addr_bits_p (addr_bits_p)
    ) i_data_ram (
        .clk      (clk),
        .strobe_i (accept),
        .req_i    (req),
        .rdata_o  (rdata)
    );

    load_align i_load_align (
        .op_i     (resp_op_q),
        .offset_i (resp_offset_q),
        .sc_ok_i  (resp_sc_ok_q),
        .ale_i    (resp_ale_q),
        .rdata_i  (rdata),
        .resp_o   (wb_o)
    );

endmodule

//--- design/mem_types.sv
package mem_types;

    // ==================================================================
    // Access width
    // ==================================================================

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_HALF = 2'd1,
        W_WORD = 2'd2
    } acc_width_e;

    // ==================================================================
    // Request to the data RAM
    // ==================================================================

    typedef struct packed {
        logic             ce;
        logic             we;
        acc_width_e       width;
        core_types::data_t addr;        // Byte address, low bits give lanes.
        logic [3:0]       sel;
        core_types::data_t data;        // Replicated across the lanes.
        logic             ale;
    } mem_cache_struct;

    // ==================================================================
    // Response to write-back
    // ==================================================================

    typedef struct packed {
        core_types::data_t result;
        logic              ale;
    } mem_resp_struct;

endpackage

//--- flist.f
design/core_types.sv
design/mem_types.sv
design/mem_req.sv
design/llbit_reg.sv
design/data_ram.sv
design/load_align.sv
design/mem_stage.sv
bench/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build the memory stage testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_stage_tb -f flist.f -o sim &&
./obj_dir/sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
